/* verilog/proto_pkg.sv */
// host link command and response formats
package proto_pkg;

  // field widths on the host link
  localparam int ADDR_W = 6;
  localparam int DATA_W = 32;

  // credit counters, wide enough for any sane depth
  localparam int CREDIT_W = 4;

  // register map
  localparam logic [ADDR_W-1:0] ADDR_GENERAL  = 6'h00;
  localparam logic [ADDR_W-1:0] ADDR_TX_DRIVE = 6'h09;
  localparam logic [ADDR_W-1:0] ADDR_VERSION  = 6'h3a;

  // one command from the host, 39 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic              resp_rqst;
  } cmd_word_t;

  // one response to the host, 40 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              tx_on;
    logic              run;
    logic [DATA_W-1:0] data;
  } resp_word_t;

endpackage

/* verilog/radio_pkg.sv */
// radio register state
package radio_pkg;

  // drive level field, top byte of the data word
  localparam int DRIVE_W = 8;

  // version readback
  localparam logic [7:0] FW_VERSION = 8'd73;

  // state as seen outside the core, 11 bits
  //   run    general run enable
  //   ptt    push to talk from the host
  //   tx_on  keyed transmit, run & ptt & ~inhibit
  //   drive  TX drive level
  typedef struct packed {
    logic               run;
    logic               ptt;
    logic               tx_on;
    logic [DRIVE_W-1:0] drive;
  } radio_state_t;

  // width of the whole state word
  localparam int STATE_W = $bits(radio_state_t);

  // all-off value after reset
  localparam radio_state_t RADIO_STATE_IDLE = '0;

endpackage

/* verilog/credit_fifo.sv */
// credit returning FWFT queue
module credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clk_ctrl,
  input  logic     arst_n_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t head_o,
  output logic     not_empty_o,
  output logic     full_o,
  output logic     credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             credit_q;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk_ctrl) begin
    if (push_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // pointers, occupancy and one credit per pop
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop_i) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit_q <= pop_i;
    end
  end

  // head is visible the cycle after its push
  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (count != '0);
  assign full_o      = (count == CNT_W'(DEPTH));
  assign credit_o    = credit_q;

  ////////////////////////////////////////////////////////////////////////////
  // checks

  // a push into a full queue means the sender spent a credit it never had
  a_no_push_full : assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    push_i |-> !full_o)
    else $error("credit_fifo: push while full");

  a_no_pop_empty : assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    pop_i |-> not_empty_o)
    else $error("credit_fifo: pop while empty");

endmodule

/* verilog/cmd_regfile.sv */
// command decode and radio registers
module cmd_regfile (
  input  logic                    clk_ctrl,
  input  logic                    arst_n_i,
  input  proto_pkg::cmd_word_t    cmd_i,
  input  logic                    cmd_ready_i,
  input  logic                    resp_full_i,
  input  logic                    tx_inhibit_i,
  output logic                    cmd_pop_o,
  output logic                    resp_push_o,
  output proto_pkg::resp_word_t   resp_o,
  output radio_pkg::radio_state_t radio_state_o
);

  import proto_pkg::*;
  import radio_pkg::*;

  radio_state_t      state_q;
  radio_state_t      state_d;
  logic [DATA_W-1:0] rdata;

  ////////////////////////////////////////////////////////////////////////////
  // pop control

  // silent commands never wait on the response side
  assign cmd_pop_o   = cmd_ready_i & (~cmd_i.resp_rqst | ~resp_full_i);
  assign resp_push_o = cmd_pop_o & cmd_i.resp_rqst;

  ////////////////////////////////////////////////////////////////////////////
  // register update

  always_comb begin
    state_d = state_q;
    if (cmd_pop_o) begin
      case (cmd_i.addr)
        ADDR_GENERAL: begin
          state_d.run = cmd_i.data[0];
          state_d.ptt = cmd_i.data[1];
        end
        ADDR_TX_DRIVE: begin
          state_d.drive = cmd_i.data[DATA_W-1 -: DRIVE_W];
        end
        default: begin
          // version is read only, unknown addresses are ignored
          state_d = state_q;
        end
      endcase
    end
    // keying follows the inhibit input every cycle
    state_d.tx_on = state_d.run & state_d.ptt & ~tx_inhibit_i;
  end

  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= RADIO_STATE_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign radio_state_o = state_q;

  ////////////////////////////////////////////////////////////////////////////
  // readback

  // values after this command's write
  always_comb begin
    case (cmd_i.addr)
      ADDR_GENERAL:  rdata = DATA_W'({state_d.ptt, state_d.run});
      ADDR_TX_DRIVE: rdata = {state_d.drive, {(DATA_W - DRIVE_W){1'b0}}};
      ADDR_VERSION:  rdata = DATA_W'(FW_VERSION);
      default:       rdata = '0;
    endcase
  end

  always_comb begin
    resp_o       = '0;
    resp_o.addr  = cmd_i.addr;
    resp_o.tx_on = state_d.tx_on;
    resp_o.run   = state_d.run;
    resp_o.data  = rdata;
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks

  // the egress queue must have room for every pushed response
  a_no_push_full : assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    resp_push_o |-> !resp_full_i)
    else $error("cmd_regfile: response push into full queue");

endmodule

/* verilog/resp_egress.sv */
// response queue and credit gated sender
module resp_egress #(
  parameter int RESP_DEPTH   = 4,
  parameter int RESP_CREDITS = 2
) (
  input  logic                  clk_ctrl,
  input  logic                  arst_n_i,
  input  logic                  push_i,
  input  proto_pkg::resp_word_t resp_i,
  input  logic                  resp_credit_i,
  output logic                  full_o,
  output logic                  resp_valid_o,
  output proto_pkg::resp_word_t resp_o
);

  import proto_pkg::*;

  resp_word_t          fifo_head;
  logic                fifo_not_empty;
  logic                send;
  logic [CREDIT_W-1:0] credit_cnt;
  logic                valid_q;
  resp_word_t          resp_q;

  credit_fifo #(
    .payload_t (resp_word_t),
    .DEPTH     (RESP_DEPTH)
  ) resp_fifo_inst (
    .clk_ctrl    (clk_ctrl),
    .arst_n_i    (arst_n_i),
    .push_i      (push_i),
    .data_i      (resp_i),
    .pop_i       (send),
    .head_o      (fifo_head),
    .not_empty_o (fifo_not_empty),
    .full_o      (full_o),
    .credit_o    ()
  );

  // head leaves as soon as a credit is held
  assign send = fifo_not_empty & (credit_cnt != '0);

  // send and grant may land in the same cycle
  always_ff @(posedge clk_ctrl or negedge arst_n_i) begin
    if (!arst_n_i) begin
      credit_cnt <= CREDIT_W'(RESP_CREDITS);
      valid_q    <= 1'b0;
    end else begin
      case ({send, resp_credit_i})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
      valid_q <= send;
    end
  end

  // outgoing word
  always_ff @(posedge clk_ctrl) begin
    if (send) begin
      resp_q <= fifo_head;
    end
  end

  assign resp_valid_o = valid_q;
  assign resp_o       = resp_q;

  // host grants more than were ever spent
  a_credit_max : assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    credit_cnt <= CREDIT_W'(RESP_CREDITS))
    else $error("resp_egress: credit count above initial grant");

  a_send_credit : assert property (@(posedge clk_ctrl) disable iff (!arst_n_i)
    resp_valid_o |-> $past(credit_cnt) != '0)
    else $error("resp_egress: response sent without a credit");

endmodule

/* verilog/ctrl_core_top.sv */
// control command core top level
module ctrl_core_top #(
  parameter int CMD_DEPTH    = 4,
  parameter int RESP_DEPTH   = 4,
  parameter int RESP_CREDITS = 2
) (
  input  logic                    clk_ctrl,
  input  logic                    arst_n_i,
  input  logic                    cmd_valid_i,
  input  proto_pkg::cmd_word_t    cmd_i,
  input  logic                    resp_credit_i,
  input  logic                    tx_inhibit_i,
  output logic                    cmd_credit_o,
  output logic                    resp_valid_o,
  output proto_pkg::resp_word_t   resp_o,
  output radio_pkg::radio_state_t radio_state_o
);

  import proto_pkg::*;

  cmd_word_t  cmd_head;
  logic       cmd_not_empty;
  logic       cmd_pop;
  logic       resp_push;
  resp_word_t resp_word;
  logic       resp_full;

  // initial grant has to fit the egress counter
  if (RESP_CREDITS > (1 << CREDIT_W) - 1) begin : g_credit_check
    $error("ctrl_core_top: RESP_CREDITS does not fit CREDIT_W");
  end

  ////////////////////////////////////////////////////////////////////////////
  // input side, host keeps CMD_DEPTH credits

  credit_fifo #(
    .payload_t (cmd_word_t),
    .DEPTH     (CMD_DEPTH)
  ) cmd_fifo_inst (
    .clk_ctrl    (clk_ctrl),
    .arst_n_i    (arst_n_i),
    .push_i      (cmd_valid_i),
    .data_i      (cmd_i),
    .pop_i       (cmd_pop),
    .head_o      (cmd_head),
    .not_empty_o (cmd_not_empty),
    .full_o      (),
    .credit_o    (cmd_credit_o)
  );

  cmd_regfile cmd_regfile_inst (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .cmd_i         (cmd_head),
    .cmd_ready_i   (cmd_not_empty),
    .resp_full_i   (resp_full),
    .tx_inhibit_i  (tx_inhibit_i),
    .cmd_pop_o     (cmd_pop),
    .resp_push_o   (resp_push),
    .resp_o        (resp_word),
    .radio_state_o (radio_state_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // output side

  resp_egress #(
    .RESP_DEPTH   (RESP_DEPTH),
    .RESP_CREDITS (RESP_CREDITS)
  ) resp_egress_inst (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .push_i        (resp_push),
    .resp_i        (resp_word),
    .resp_credit_i (resp_credit_i),
    .full_o        (resp_full),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o)
  );

endmodule

/* verif/ctrl_core_vectors.svh */
// control core test vectors
`ifndef CTRL_CORE_VECTORS_SVH
`define CTRL_CORE_VECTORS_SVH

// columns: test, {addr, data, resp_rqst}, inhibit, resp expected,
//          {addr, tx_on, run, data}, {run, ptt, tx_on, drive}
localparam int N_VEC = 12;

vec_t vectors [N_VEC] = '{
  '{2, '{ADDR_GENERAL, 32'h0000_0001, 1'b1}, 1'b0, 1'b1,
       '{ADDR_GENERAL, 1'b0, 1'b1, 32'h0000_0001}, '{1'b1, 1'b0, 1'b0, 8'h00}},
  '{2, '{ADDR_TX_DRIVE, 32'ha500_0000, 1'b1}, 1'b0, 1'b1,
       '{ADDR_TX_DRIVE, 1'b0, 1'b1, 32'ha500_0000}, '{1'b1, 1'b0, 1'b0, 8'ha5}},
  '{2, '{ADDR_VERSION, 32'h0000_0000, 1'b1}, 1'b0, 1'b1,
       '{ADDR_VERSION, 1'b0, 1'b1, 32'd73}, '{1'b1, 1'b0, 1'b0, 8'ha5}},
  '{2, '{ADDR_GENERAL, 32'h0000_0000, 1'b1}, 1'b0, 1'b1,
       '{ADDR_GENERAL, 1'b0, 1'b0, 32'h0000_0000}, '{1'b0, 1'b0, 1'b0, 8'ha5}},
  // keying combinations
  '{3, '{ADDR_GENERAL, 32'h0000_0003, 1'b1}, 1'b0, 1'b1,
       '{ADDR_GENERAL, 1'b1, 1'b1, 32'h0000_0003}, '{1'b1, 1'b1, 1'b1, 8'ha5}},
  '{3, '{ADDR_GENERAL, 32'h0000_0003, 1'b1}, 1'b1, 1'b1,
       '{ADDR_GENERAL, 1'b0, 1'b1, 32'h0000_0003}, '{1'b1, 1'b1, 1'b0, 8'ha5}},
  '{3, '{ADDR_GENERAL, 32'h0000_0002, 1'b1}, 1'b0, 1'b1,
       '{ADDR_GENERAL, 1'b0, 1'b0, 32'h0000_0002}, '{1'b0, 1'b1, 1'b0, 8'ha5}},
  '{3, '{ADDR_GENERAL, 32'h0000_0003, 1'b1}, 1'b0, 1'b1,
       '{ADDR_GENERAL, 1'b1, 1'b1, 32'h0000_0003}, '{1'b1, 1'b1, 1'b1, 8'ha5}},
  // unused address, then silent writes
  '{4, '{6'h15, 32'hffff_ffff, 1'b1}, 1'b0, 1'b1,
       '{6'h15, 1'b1, 1'b1, 32'h0000_0000}, '{1'b1, 1'b1, 1'b1, 8'ha5}},
  '{4, '{ADDR_TX_DRIVE, 32'h3c00_0000, 1'b0}, 1'b0, 1'b0,
       '{6'h00, 1'b0, 1'b0, 32'h0}, '{1'b1, 1'b1, 1'b1, 8'h3c}},
  '{4, '{ADDR_GENERAL, 32'h0000_0000, 1'b0}, 1'b0, 1'b0,
       '{6'h00, 1'b0, 1'b0, 32'h0}, '{1'b0, 1'b0, 1'b0, 8'h3c}},
  '{4, '{ADDR_GENERAL, 32'h0000_0003, 1'b1}, 1'b1, 1'b1,
       '{ADDR_GENERAL, 1'b0, 1'b1, 32'h0000_0003}, '{1'b1, 1'b1, 1'b0, 8'h3c}}
};

`endif

/* verif/ctrl_core_tb.sv */
// control core testbench
module ctrl_core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import proto_pkg::*;
  import radio_pkg::*;

  localparam int CMD_DEPTH    = 4;
  localparam int RESP_DEPTH   = 4;
  localparam int RESP_CREDITS = 2;
  localparam int N_BURST      = 10;

  typedef struct {
    int           test_id;
    cmd_word_t    cmd;
    logic         inhibit;
    logic         exp_resp;
    resp_word_t   exp;
    radio_state_t exp_state;
  } vec_t;

  `include "ctrl_core_vectors.svh"

  localparam int TIMEOUT_CYCLES = (N_VEC + 16) * 40;

  logic         clk_ctrl = 1'b0;
  logic         arst_n_i;
  logic         cmd_valid_i;
  cmd_word_t    cmd_i;
  logic         resp_credit_i;
  logic         tx_inhibit_i;
  logic         cmd_credit_o;
  logic         resp_valid_o;
  resp_word_t   resp_o;
  radio_state_t radio_state_o;

  resp_word_t   resp_q [$];
  int           resp_total = 0;
  int           ret_cnt    = 0;
  int           sent_cnt   = 0;
  int           grants     = 0;
  bit           hold_grants = 1'b0;
  int           err_cnt    = 0;
  int           tests_ok   = 0;
  int           tests_bad  = 0;

  ctrl_core_top #(
    .CMD_DEPTH    (CMD_DEPTH),
    .RESP_DEPTH   (RESP_DEPTH),
    .RESP_CREDITS (RESP_CREDITS)
  ) ctrl_core_top_inst (
    .clk_ctrl      (clk_ctrl),
    .arst_n_i      (arst_n_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .resp_credit_i (resp_credit_i),
    .tx_inhibit_i  (tx_inhibit_i),
    .cmd_credit_o  (cmd_credit_o),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .radio_state_o (radio_state_o)
  );

  always #5 clk_ctrl = ~clk_ctrl;

  ////////////////////////////////////////////////////////////////////////////
  // monitor and response credit grants, both on the falling edge

  always @(negedge clk_ctrl) begin
    if (arst_n_i) begin
      if (resp_valid_o) begin
        resp_q.push_back(resp_o);
        resp_total++;
      end
      if (cmd_credit_o) begin
        ret_cnt++;
      end
    end
    // one grant per received response
    resp_credit_i = 1'b0;
    if (!hold_grants && grants < resp_total) begin
      resp_credit_i = 1'b1;
      grants++;
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 10);
    $display("watchdog expired after %0d cycles, DUT stopped responding", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  function automatic int host_credits();
    return CMD_DEPTH - sent_cnt + ret_cnt;
  endfunction

  task automatic check_resp(input resp_word_t got, input resp_word_t exp, input string what);
    if (got !== exp) begin
      $display("Error: %0d ns: %s response %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_state(input radio_state_t got, input radio_state_t exp,
                             input string what);
    if (got !== exp) begin
      $display("Error: %0d ns: %s radio state %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  // called on a falling edge, returns on a falling edge
  task automatic send_cmd(input cmd_word_t cmd);
    while (host_credits() == 0) begin
      @(negedge clk_ctrl);
    end
    cmd_valid_i = 1'b1;
    cmd_i       = cmd;
    sent_cnt++;
    @(negedge clk_ctrl);
    cmd_valid_i = 1'b0;
  endtask

  task automatic wait_resps(input int target, input int limit);
    int n;
    n = 0;
    while (resp_total < target && n < limit) begin
      @(negedge clk_ctrl);
      n++;
    end
    if (resp_total < target) begin
      $display("missing response: got %0d of %0d by %0d ns", resp_total, target, $time);
      err_cnt++;
    end
  endtask

  task automatic wait_credits(input int limit);
    int n;
    n = 0;
    while (host_credits() != CMD_DEPTH && n < limit) begin
      @(negedge clk_ctrl);
      n++;
    end
    if (host_credits() != CMD_DEPTH) begin
      $display("command credits never came back, %0d held at %0d ns", host_credits(), $time);
      err_cnt++;
    end
  endtask

  task automatic report_test(input int id, input int errs_before);
    if (err_cnt == errs_before) begin
      $display("test %0d ok", id);
      tests_ok++;
    end else begin
      $display("test %0d failed with %0d errors", id, err_cnt - errs_before);
      tests_bad++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    int         group_start;
    int         base_resp;
    int         base_ret;
    logic [7:0] drive [N_BURST];
    cmd_word_t  cmd;
    resp_word_t exp;
    radio_state_t last_state;

    void'($urandom(32'h9e56_4984));
    arst_n_i      = 1'b0;
    cmd_valid_i   = 1'b0;
    cmd_i         = '0;
    resp_credit_i = 1'b0;
    tx_inhibit_i  = 1'b0;
    repeat (8) @(posedge clk_ctrl);
    @(negedge clk_ctrl);
    arst_n_i = 1'b1;

    // test 1, quiet after reset
    group_start = err_cnt;
    repeat (10) begin
      @(negedge clk_ctrl);
      check_state(radio_state_o, '0, "reset");
    end
    if (resp_total != 0 || ret_cnt != 0) begin
      $display("unexpected pulse after reset: %0d responses, %0d credits",
               resp_total, ret_cnt);
      err_cnt++;
    end
    report_test(1, group_start);

    // tests 2 to 4 from the table
    group_start = err_cnt;
    for (int i = 0; i < N_VEC; i++) begin
      base_resp    = resp_total;
      tx_inhibit_i = vectors[i].inhibit;
      send_cmd(vectors[i].cmd);
      if (vectors[i].exp_resp) begin
        wait_resps(base_resp + 1, 50);
      end
      wait_credits(50);
      repeat (3) @(negedge clk_ctrl);
      if (vectors[i].exp_resp && resp_q.size() > 0) begin
        check_resp(resp_q.pop_front(), vectors[i].exp, $sformatf("entry %0d", i));
      end
      check_state(radio_state_o, vectors[i].exp_state, $sformatf("entry %0d", i));
      if (resp_q.size() != 0) begin
        $display("extra response after entry %0d at %0d ns", i, $time);
        err_cnt++;
        resp_q.delete();
      end
      if (i == N_VEC - 1 || vectors[i + 1].test_id != vectors[i].test_id) begin
        report_test(vectors[i].test_id, group_start);
        group_start = err_cnt;
      end
    end
    last_state = vectors[N_VEC - 1].exp_state;

    // test 5, grants withheld, then released
    group_start = err_cnt;
    hold_grants = 1'b1;
    base_resp   = resp_total;
    base_ret    = ret_cnt;
    for (int i = 0; i < N_BURST; i++) begin
      drive[i] = 8'($urandom);
      cmd      = '{ADDR_TX_DRIVE, {drive[i], 24'h0}, 1'b1};
      send_cmd(cmd);
    end
    repeat (30) @(negedge clk_ctrl);
    if (resp_total - base_resp != RESP_CREDITS || host_credits() != 0) begin
      $display("back-pressure broken: %0d responses out, %0d command credits held",
               resp_total - base_resp, host_credits());
      err_cnt++;
    end
    hold_grants = 1'b0;
    wait_resps(base_resp + N_BURST, 200);
    wait_credits(50);
    repeat (10) @(negedge clk_ctrl);
    for (int i = 0; i < N_BURST; i++) begin
      exp = '{ADDR_TX_DRIVE, last_state.tx_on, last_state.run, {drive[i], 24'h0}};
      if (resp_q.size() > 0) begin
        check_resp(resp_q.pop_front(), exp, $sformatf("burst %0d", i));
      end
    end
    if (resp_q.size() != 0) begin
      $display("%0d extra responses after the burst", resp_q.size());
      err_cnt++;
    end
    if (ret_cnt - base_ret != N_BURST) begin
      $display("burst returned %0d command credits instead of %0d",
               ret_cnt - base_ret, N_BURST);
      err_cnt++;
    end
    report_test(5, group_start);

    $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+verif
verilog/proto_pkg.sv
verilog/radio_pkg.sv
verilog/credit_fifo.sv
verilog/cmd_regfile.sv
verilog/resp_egress.sv
verilog/ctrl_core_top.sv
verif/ctrl_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the control core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module ctrl_core_tb -o ctrl_core_sim \
  && ./obj_dir/ctrl_core_sim | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
